// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := banked_memory_tb
FILELIST := banked_memory.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output goes to the terminal and is searched for the pass line.
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== banked_memory.f ====
src/banked_memory_pkg.sv
src/mem_arbiter.sv
src/bank_translator.sv
src/phys_store.sv
src/banked_memory.sv
verification/banked_memory_tb.sv

// ==== src/bank_translator.sv ====
`timescale 1ns/1ps

module bank_translator import banked_memory_pkg::*; (
   input  logic                   w,
   input  logic                   mem,
   input  logic                   gnt_valid,
   input  arb_grant_t             gnt,
   output logic                   acc_valid,
   output logic                   acc_write,
   output logic [PHYS_ADDR_W-1:0] acc_addr,
   output logic [DATA_W-1:0]      acc_wdata,
   output logic                   acc_port,
   output logic                   io_hit,
   output logic [DATA_W-1:0]      io_rdata
);

   logic [PAGE_W-1:0]   bank_reg [NUM_BANKS]; // One page number per window.
   logic                bank_enable;          // Register mapping in force.
   logic [WINDOW_W-1:0] window;
   logic [IO_SEL_W-1:0] reg_sel;              // Register picked by an I/O access.
   logic [PAGE_W-1:0]   default_page;
   logic [PAGE_W-1:0]   page;
   logic                io_wr;

   ////////////////////////////////////////////////////////////
   // Address decode.
   ////////////////////////////////////////////////////////////

   assign window  = gnt.req.addr.fields.window;         // Memory view.
   assign reg_sel = gnt.req.addr.raw[IO_SEL_W-1:0];     // I/O view.

   // Boot map: {A15, 00000, A14, A13}. Low half is RAM, high half is ROM.
   assign default_page = {window[WINDOW_W-1], {(PAGE_W-WINDOW_W){1'b0}},
                          window[WINDOW_W-2:0]};

   assign page = bank_enable ? bank_reg[window] : default_page;

   assign io_wr = gnt_valid && (gnt.req.op == io_write);

   ////////////////////////////////////////////////////////////
   // Access to the store.
   ////////////////////////////////////////////////////////////

   // Every grant reaches the store so that each one gets a response.
   assign acc_valid = gnt_valid;
   assign acc_write = gnt_valid && (gnt.req.op == mem_write); // RAM/ROM write only.
   assign acc_addr  = {page, gnt.req.addr.fields.offset};
   assign acc_wdata = gnt.req.wdata;
   assign acc_port  = gnt.port_id;

   // Register reads bypass the arrays.
   assign io_hit   = gnt_valid && (gnt.req.op == io_read);
   assign io_rdata = {{(DATA_W-PAGE_W){1'b0}}, bank_reg[reg_sel]}; // Zero upper byte.

   ////////////////////////////////////////////////////////////
   // Bank registers.
   ////////////////////////////////////////////////////////////

   always_ff @(posedge w or posedge mem) begin
      if (mem) begin
         for (int i = 0; i < NUM_BANKS; i++) begin
            bank_reg[i] <= '0;
         end
         bank_enable <= 1'b0; // Boot map.
      end else if (io_wr) begin
         bank_reg[reg_sel] <= gnt.req.wdata[PAGE_W-1:0]; // Low byte only.
         // Registers 4-7 switch on register mapping for good.
         if (reg_sel[IO_SEL_W-1]) begin
            bank_enable <= 1'b1;
         end
      end
   end

   // Once on, mapping stays on until reset.
   a_bank_enable_sticky : assert property (@(posedge w) disable iff (mem)
      bank_enable |=> bank_enable);

endmodule

// ==== src/banked_memory.sv ====
`timescale 1ns/1ps

module banked_memory import banked_memory_pkg::*; (
   input  logic     w,
   input  logic     mem,
   input  logic     cpu_req_valid,
   input  mem_req_t cpu_req,
   input  logic     dma_req_valid,
   input  mem_req_t dma_req,
   output logic     cpu_rsp_valid,
   output mem_rsp_t cpu_rsp,
   output logic     dma_rsp_valid,
   output mem_rsp_t dma_rsp
);

   logic                   gnt_valid;
   arb_grant_t             gnt;
   logic                   acc_valid;
   logic                   acc_write;
   logic [PHYS_ADDR_W-1:0] acc_addr;
   logic [DATA_W-1:0]      acc_wdata;
   logic                   acc_port;
   logic                   io_hit;
   logic [DATA_W-1:0]      io_rdata;
   logic                   rsp_valid;
   logic                   rsp_port;
   mem_rsp_t               rsp;

   ////////////////////////////////////////////////////////////
   // Arbiter, translator, store.
   ////////////////////////////////////////////////////////////

   mem_arbiter i_arbiter (
      .w             (w),
      .mem           (mem),
      .cpu_req_valid (cpu_req_valid),
      .cpu_req       (cpu_req),
      .dma_req_valid (dma_req_valid),
      .dma_req       (dma_req),
      .gnt_valid     (gnt_valid),
      .gnt           (gnt)
   );

   bank_translator i_translator (
      .w         (w),
      .mem       (mem),
      .gnt_valid (gnt_valid),
      .gnt       (gnt),
      .acc_valid (acc_valid),
      .acc_write (acc_write),
      .acc_addr  (acc_addr),
      .acc_wdata (acc_wdata),
      .acc_port  (acc_port),
      .io_hit    (io_hit),
      .io_rdata  (io_rdata)
   );

   phys_store i_store (
      .w         (w),
      .mem       (mem),
      .acc_valid (acc_valid),
      .acc_write (acc_write),
      .acc_addr  (acc_addr),
      .acc_wdata (acc_wdata),
      .acc_port  (acc_port),
      .io_hit    (io_hit),
      .io_rdata  (io_rdata),
      .rsp_valid (rsp_valid),
      .rsp_port  (rsp_port),
      .rsp       (rsp)
   );

   // Steer the response back to its owner. Data goes to both, only the strobe is split.
   assign cpu_rsp_valid = rsp_valid && !rsp_port;
   assign dma_rsp_valid = rsp_valid && rsp_port;
   assign cpu_rsp       = rsp;
   assign dma_rsp       = rsp;

endmodule

// ==== src/banked_memory_pkg.sv ====
package banked_memory_pkg;

   ////////////////////////////////////////////////////////////
   // Address and data widths.
   ////////////////////////////////////////////////////////////

   localparam int LOG_ADDR_W  = 16;                    // CPU logical address.
   localparam int OFFSET_W    = 13;                    // 8 kW per window.
   localparam int WINDOW_W    = LOG_ADDR_W - OFFSET_W; // Top bits pick the window.
   localparam int NUM_BANKS   = 2 ** WINDOW_W;         // One bank register per window.
   localparam int IO_SEL_W    = 3;                     // A2..A0 select a bank register.
   localparam int PAGE_W      = 8;                     // Bank register width.
   localparam int PHYS_ADDR_W = PAGE_W + OFFSET_W;     // 21 bits, 2 MW physical.
   localparam int DATA_W      = 16;

   ////////////////////////////////////////////////////////////
   // Physical map.
   ////////////////////////////////////////////////////////////

   // RAM and ROM are 512 kW each.
   localparam int REGION_W = 19;

   // Region codes sit in physical bits 20..19.
   localparam logic [PHYS_ADDR_W-REGION_W-1:0] RAM_REGION = 2'b00; // Pages 0x00-0x3F.
   localparam logic [PHYS_ADDR_W-REGION_W-1:0] ROM_REGION = 2'b10; // Pages 0x80-0xBF.

   localparam logic [DATA_W-1:0] HOLE_DATA = 16'hFFFF; // Floating bus reads as all ones.

   localparam string ROM_IMAGE = "src/rom_image.hex"; // Boot image for the ROM.

   ////////////////////////////////////////////////////////////
   // Request, response and grant types.
   ////////////////////////////////////////////////////////////

   // Bit 1 marks an I/O operation, bit 0 a write.
   typedef enum logic [1:0] {
      mem_read  = 2'b00,
      mem_write = 2'b01,
      io_read   = 2'b10,
      io_write  = 2'b11
   } mem_op_e;

   typedef struct packed {
      logic [WINDOW_W-1:0] window; // A15..A13.
      logic [OFFSET_W-1:0] offset; // A12..A0.
   } addr_fields_t;

   // Memory operations split the address into window and offset.
   // I/O operations use the raw word.
   typedef union packed {
      logic [LOG_ADDR_W-1:0] raw;
      addr_fields_t          fields;
   } logical_addr_u;

   typedef struct packed {
      mem_op_e           op;
      logical_addr_u     addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata; // Only meaningful for reads.
   } mem_rsp_t;

   typedef struct packed {
      mem_req_t req;
      logic     port_id; // 0 is cpu, 1 is dma.
   } arb_grant_t;

endpackage

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter import banked_memory_pkg::*; (
   input  logic       w,
   input  logic       mem,
   input  logic       cpu_req_valid,
   input  mem_req_t   cpu_req,
   input  logic       dma_req_valid,
   input  mem_req_t   dma_req,
   output logic       gnt_valid,
   output arb_grant_t gnt
);

   logic     cpu_pend;  // Cpu slot holds a request.
   logic     dma_pend;  // Dma slot holds a request.
   mem_req_t cpu_slot;
   mem_req_t dma_slot;
   logic     last_dma;  // Dma won the last grant.
   logic     pick_dma;  // Dma wins this cycle.

   ////////////////////////////////////////////////////////////
   // Grant selection.
   ////////////////////////////////////////////////////////////

   // Dma wins when it waits alone, or when both wait and cpu won last.
   assign pick_dma = dma_pend && (!cpu_pend || !last_dma);

   assign gnt_valid   = cpu_pend || dma_pend;             // Any slot full.
   assign gnt.req     = pick_dma ? dma_slot : cpu_slot;
   assign gnt.port_id = pick_dma;

   ////////////////////////////////////////////////////////////
   // Pending slots.
   ////////////////////////////////////////////////////////////

   always_ff @(posedge w or posedge mem) begin
      if (mem) begin
         cpu_pend <= 1'b0;
         dma_pend <= 1'b0;
         last_dma <= 1'b1; // Cpu goes first after reset.
      end else begin
         // A strobe never meets a full slot, so fill and drain do not collide.
         if (cpu_req_valid) begin
            cpu_pend <= 1'b1;
         end else if (gnt_valid && !pick_dma) begin
            cpu_pend <= 1'b0; // Granted, slot drains.
         end
         if (dma_req_valid) begin
            dma_pend <= 1'b1;
         end else if (gnt_valid && pick_dma) begin
            dma_pend <= 1'b0;
         end
         if (gnt_valid) begin
            last_dma <= pick_dma; // Remember the winner.
         end
      end
   end

   // Request payload, sampled with its strobe.
   always_ff @(posedge w) begin
      if (cpu_req_valid) begin
         cpu_slot <= cpu_req;
      end
      if (dma_req_valid) begin
         dma_slot <= dma_req;
      end
   end

   // Each port waits for its response, and that comes after the slot drained.
   a_cpu_one_outstanding : assert property (@(posedge w) disable iff (mem)
      cpu_req_valid |-> !cpu_pend);

   a_dma_one_outstanding : assert property (@(posedge w) disable iff (mem)
      dma_req_valid |-> !dma_pend);

   // A lone request drains in its grant cycle, so the grant does not linger.
   a_grant_drains : assert property (@(posedge w) disable iff (mem)
      gnt_valid && !(cpu_pend && dma_pend) && !cpu_req_valid && !dma_req_valid
      |=> !gnt_valid);

endmodule

// ==== src/phys_store.sv ====
`timescale 1ns/1ps

module phys_store import banked_memory_pkg::*; (
   input  logic                   w,
   input  logic                   mem,
   input  logic                   acc_valid,
   input  logic                   acc_write,
   input  logic [PHYS_ADDR_W-1:0] acc_addr,
   input  logic [DATA_W-1:0]      acc_wdata,
   input  logic                   acc_port,
   input  logic                   io_hit,
   input  logic [DATA_W-1:0]      io_rdata,
   output logic                   rsp_valid,
   output logic                   rsp_port,
   output mem_rsp_t               rsp
);

   logic [DATA_W-1:0] ram [2**REGION_W]; // 512 kW RAM.
   logic [DATA_W-1:0] rom [2**REGION_W]; // 512 kW ROM.

   logic [PHYS_ADDR_W-REGION_W-1:0] region; // Physical bits 20..19.
   logic [REGION_W-1:0]             word;   // Word within the region.
   logic                            ram_sel;
   logic                            rom_sel;
   logic [DATA_W-1:0]               rd_data;

   ////////////////////////////////////////////////////////////
   // Region decode.
   ////////////////////////////////////////////////////////////

   assign region  = acc_addr[PHYS_ADDR_W-1:REGION_W];
   assign word    = acc_addr[REGION_W-1:0];
   assign ram_sel = (region == RAM_REGION);
   assign rom_sel = (region == ROM_REGION);

   // Anything outside RAM and ROM is a hole.
   always_comb begin
      if (io_hit) begin
         rd_data = io_rdata;         // Bank register read.
      end else if (ram_sel) begin
         rd_data = ram[word];
      end else if (rom_sel) begin
         rd_data = rom[word];
      end else begin
         rd_data = HOLE_DATA;        // Unmapped page.
      end
   end

   ////////////////////////////////////////////////////////////
   // Arrays.
   ////////////////////////////////////////////////////////////

   // Boot image.
   initial begin
      $readmemh(ROM_IMAGE, rom);
   end

   // Writes to ROM or to a hole fall on the floor.
   always_ff @(posedge w) begin
      if (acc_valid && acc_write && ram_sel) begin
         ram[word] <= acc_wdata;
      end
   end

   ////////////////////////////////////////////////////////////
   // Response register.
   ////////////////////////////////////////////////////////////

   always_ff @(posedge w or posedge mem) begin
      if (mem) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= acc_valid; // One response per access, writes included.
      end
   end

   always_ff @(posedge w) begin
      if (acc_valid) begin
         rsp.rdata <= rd_data;   // Read data, don't care for writes.
         rsp_port  <= acc_port;  // Owner travels with the data.
      end
   end

   // Every grant comes back the next cycle, still tagged with its owner.
   a_rsp_follows_acc : assert property (@(posedge w) disable iff (mem)
      acc_valid |=> rsp_valid && (rsp_port == $past(acc_port)));

   a_no_stray_rsp : assert property (@(posedge w) disable iff (mem)
      !acc_valid |=> !rsp_valid);

endmodule

// ==== src/rom_image.hex ====
// ROM boot image. One 16-bit hex word per line, @ sets the word address.
// Words not listed stay unset.
@00000
C0DE
1234
5678
9ABC
@02000
2BAD
@07FF0
F00D
FACE
@7FFFF
0000

// ==== verification/banked_memory_stimulus.txt ====
# Columns: port op addr wdata expect pair, all hex.
# port 0 cpu, 1 dma. op 0 mem_read, 1 mem_write, 2 io_read, 3 io_write.
# expect is checked for reads only. pair 1 strobes this line together with the next.
# A line "test <name>" starts a new test.
test default_map
0 0 8000 0000 C0DE 0
1 0 FFF0 0000 F00D 0
1 0 8003 0000 9ABC 0
test ram_default_map
0 1 0000 1111 0000 0
1 1 7FFF 7FFF 0000 0
0 0 0000 0000 1111 0
1 0 7FFF 0000 7FFF 0
0 1 8000 DEAD 0000 0
1 0 8000 0000 C0DE 0
test bank_registers
0 3 0000 1205 0000 0
1 3 0001 0006 0000 0
0 3 0002 0080 0000 0
1 3 0003 0040 0000 0
0 2 0000 0000 0005 0
0 2 0001 0000 0006 0
1 2 0102 0000 0080 0
0 2 FFF3 0000 0040 0
1 0 8000 0000 C0DE 0
0 3 0004 0000 0000 0
1 0 8000 0000 1111 0
0 3 0005 00C0 0000 0
1 3 0006 0081 0000 0
0 3 0007 0007 0000 0
test register_mapping
0 1 0010 AAAA 0000 0
1 1 2010 BBBB 0000 0
0 0 0010 0000 AAAA 0
1 0 2010 0000 BBBB 0
0 0 4000 0000 C0DE 0
1 0 C000 0000 2BAD 0
0 1 4001 7777 0000 0
0 0 4001 0000 1234 0
1 0 6000 0000 FFFF 0
1 1 6000 5555 0000 0
1 0 6000 0000 FFFF 0
0 1 A123 6666 0000 0
0 0 A123 0000 FFFF 0
1 2 0005 0000 00C0 0
test concurrent
0 0 0010 0000 AAAA 1
1 0 2010 0000 BBBB 0
0 1 E010 DDDD 0000 1
1 0 4000 0000 C0DE 0
1 1 2345 4321 0000 1
0 0 E010 0000 DDDD 0
1 1 0010 AAAA 0000 1
0 0 0010 0000 AAAA 0
0 0 2345 0000 4321 0

// ==== verification/banked_memory_tb.sv ====
`timescale 1ns/1ps

module banked_memory_tb import banked_memory_pkg::*; ();

   localparam string STIM_FILE = "verification/banked_memory_stimulus.txt";

   // One operation line of the stimulus file.
   typedef struct packed {
      logic              port;     // 0 cpu, 1 dma.
      mem_op_e           op;
      logic [15:0]       addr;
      logic [DATA_W-1:0] wdata;
      logic [DATA_W-1:0] exp_data; // Expected read data.
      logic              pair;     // Strobe together with the next line.
      logic [7:0]        test_no;
   } stim_op_t;

   logic     w = 1'b0;
   logic     mem;
   logic     cpu_req_valid;
   mem_req_t cpu_req;
   logic     dma_req_valid;
   mem_req_t dma_req;
   logic     cpu_rsp_valid;
   mem_rsp_t cpu_rsp;
   logic     dma_rsp_valid;
   mem_rsp_t dma_rsp;

   stim_op_t ops[$];
   string    test_names[$];
   bit       test_bad;         // Current test saw a failing check.
   int       tests_passed = 0;
   int       tests_failed = 0;
   int       cycle_count = 0;
   int       cycle_limit = 100;

   banked_memory i_dut (
      .w             (w),
      .mem           (mem),
      .cpu_req_valid (cpu_req_valid),
      .cpu_req       (cpu_req),
      .dma_req_valid (dma_req_valid),
      .dma_req       (dma_req),
      .cpu_rsp_valid (cpu_rsp_valid),
      .cpu_rsp       (cpu_rsp),
      .dma_rsp_valid (dma_rsp_valid),
      .dma_rsp       (dma_rsp)
   );

   always #4 w = ~w; // 8 ns period.

   // Hang guard.
   always @(posedge w) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus file.
   ////////////////////////////////////////////////////////////

   task automatic load_stimulus(output bit ok);
      int       fd;
      int       i;
      int       f_port, f_op, f_addr, f_wdata, f_exp, f_pair;
      string    line;
      stim_op_t s;
      ok = 1'b1;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open stimulus file %s", STIM_FILE);
         ok = 1'b0;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) continue;
            if (line.len() < 2 || line.getc(0) == "#") continue; // Blank or comment.
            if (line.substr(0, 4) == "test ") begin
               test_names.push_back(line.substr(5, line.len() - 2)); // Drop newline.
            end else if ($sscanf(line, "%h %h %h %h %h %h", f_port, f_op, f_addr,
                                 f_wdata, f_exp, f_pair) == 6 && test_names.size() > 0) begin
               s.port     = f_port[0];
               s.op       = mem_op_e'(f_op[1:0]);
               s.addr     = f_addr[15:0];
               s.wdata    = f_wdata[15:0];
               s.exp_data = f_exp[15:0];
               s.pair     = f_pair[0];
               s.test_no  = 8'(test_names.size() - 1);
               ops.push_back(s);
            end else begin
               $display("Stimulus line not understood: %s", line);
               ok = 1'b0;
            end
         end
         $fclose(fd);
      end
      // A pair needs a partner on the other port in the same test.
      for (i = 0; i < ops.size(); i++) begin
         if (ops[i].pair && (i + 1 >= ops.size() || ops[i + 1].port == ops[i].port ||
                             ops[i + 1].test_no != ops[i].test_no)) begin
            $display("Paired stimulus operation %0d has no partner on the other port", i);
            ok = 1'b0;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Driving and checking.
   ////////////////////////////////////////////////////////////

   function automatic mem_req_t to_req(input stim_op_t s);
      mem_req_t r;
      r.op       = s.op;
      r.addr.raw = s.addr;
      r.wdata    = s.wdata;
      return r;
   endfunction

   task automatic check_port(input string name, input bit wanted, input stim_op_t s,
                             input int n, input logic [DATA_W-1:0] d);
      if (!wanted) begin
         assert (n == 0) else begin
            $display("%0d ns: %s port answered without a request", $time, name);
            test_bad = 1'b1;
         end
      end else begin
         assert (n == 1) else begin
            $display("%0d ns: %s port gave %0d responses to the request at %h, not one",
                     $time, name, n, s.addr);
            test_bad = 1'b1;
         end
         // Writes return no data worth checking.
         if (n == 1 && (s.op == mem_read || s.op == io_read)) begin
            assert (d == s.exp_data) else begin
               $display("** Error at %0d ns: %s read of %h expected %h, got %h",
                        $time, name, s.addr, s.exp_data, d);
               test_bad = 1'b1;
            end
         end
      end
   endtask

   // Strobe one operation, or a pair on both ports, and collect the responses.
   task automatic run_slot(input stim_op_t a, input stim_op_t b, input bit paired);
      int                n_cpu, n_dma, c;
      logic [DATA_W-1:0] d_cpu, d_dma;
      bit                want_cpu, want_dma;
      stim_op_t          op_cpu, op_dma;
      want_cpu = (a.port == 1'b0) || (paired && b.port == 1'b0);
      want_dma = (a.port == 1'b1) || (paired && b.port == 1'b1);
      op_cpu   = (a.port == 1'b0) ? a : b;
      op_dma   = (a.port == 1'b1) ? a : b;
      n_cpu = 0;
      n_dma = 0;
      c     = 0;
      d_cpu = '0;
      d_dma = '0;
      @(posedge w);
      #1;
      cpu_req_valid = want_cpu;
      dma_req_valid = want_dma;
      cpu_req       = to_req(op_cpu);
      dma_req       = to_req(op_dma);
      // Loser of arbitration answers 3 cycles after its strobe.
      while (c < 3 && !((n_cpu > 0 || !want_cpu) && (n_dma > 0 || !want_dma))) begin
         @(posedge w);
         if (c == 0) begin
            #1;
            cpu_req_valid = 1'b0; // Single-cycle strobe.
            dma_req_valid = 1'b0;
         end
         @(negedge w);           // Outputs settled.
         if (cpu_rsp_valid) begin
            n_cpu++;
            d_cpu = cpu_rsp.rdata;
         end
         if (dma_rsp_valid) begin
            n_dma++;
            d_dma = dma_rsp.rdata;
         end
         c++;
      end
      check_port("cpu", want_cpu, op_cpu, n_cpu, d_cpu);
      check_port("dma", want_dma, op_dma, n_dma, d_dma);
   endtask

   // Nothing may answer once every request is served.
   task automatic check_idle();
      repeat (3) begin
         @(negedge w);
         assert (!cpu_rsp_valid && !dma_rsp_valid) else begin
            $display("%0d ns: response strobe with no request outstanding", $time);
            test_bad = 1'b1;
         end
      end
   endtask

   task automatic finish_test(input logic [7:0] no);
      if (test_bad) begin
         tests_failed++;
         $display("Test %0s: FAIL", test_names[no]);
      end else begin
         tests_passed++;
         $display("Test %0s: PASS", test_names[no]);
      end
      test_bad = 1'b0;
   endtask

   task automatic run_tests();
      int i;
      i        = 0;
      test_bad = 1'b0;
      while (i < ops.size()) begin
         if (ops[i].pair) begin
            run_slot(ops[i], ops[i + 1], 1'b1);
            i += 2;
         end else begin
            run_slot(ops[i], ops[i], 1'b0);
            i += 1;
         end
         if (i >= ops.size()) begin
            check_idle(); // Strays after the last operation.
         end
         if (i >= ops.size() || ops[i].test_no != ops[i - 1].test_no) begin
            finish_test(ops[i - 1].test_no);
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence.
   ////////////////////////////////////////////////////////////

   initial begin
      bit ok;
      mem           = 1'b1;
      cpu_req_valid = 1'b0;
      cpu_req       = '0;
      dma_req_valid = 1'b0;
      dma_req       = '0;
      load_stimulus(ok);
      cycle_limit = 3 * ops.size() + 100;
      if (!ok) begin
         $display("Simulation failed");
      end else begin
         repeat (16) @(posedge w);
         #1 mem = 1'b0;
         run_tests();
         $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
         if (tests_failed == 0 && tests_passed > 0) begin
            $display("Simulation passed");
         end else begin
            $display("Simulation failed");
         end
      end
      $finish;
   end

endmodule
